/* filelist.f */
+incdir+source
source/awe_types_pkg.sv
source/awe_ctrl_pkg.sv
source/delay_line.sv
source/row_buf_ram.sv
source/load_aligner.sv
source/engine_bank.sv
source/awe_row_buffers.sv
sim/awe_checker.sv
sim/tb_awe_row_buffers.sv

/* sim/tb_awe_row_buffers.sv */
`timescale 1ns/1ps
`include "awe_defines.svh"

module tb_awe_row_buffers;

    import awe_types_pkg::*;
    import awe_ctrl_pkg::*;

    localparam int N         = `AWE_NUM_ENGINES;
    localparam int MAX_STEPS = 512;

    // Stimulus and expected pair per engine for one table row
    typedef struct packed {
        awe_state_t          state;
        load_req_t           load;
        engine_pixels_t      pix;
        col_t                num_cols;
        gray_t               gray;
        seq_word_t           seq;
        logic [N-1:0]        start;
        logic                row_matric;
        logic                last_kernel;
        col_t                wr_col;
        pixel_pair_t [N-1:0] exp;
    } step_t;

    logic                clk;
    logic                rst;
    awe_state_t          state;
    load_req_t           load;
    engine_pixels_t      pix_in;
    col_t                num_input_cols;
    gray_t               gray_code;
    seq_word_t           seq_word;
    logic [N-1:0]        ce_start;
    logic                row_matric;
    logic                last_kernel;
    col_t                wr_col;
    pixel_pair_t [N-1:0] pair_out;
    logic [N-1:0]        pair_valid;

    logic [N-1:0]        exp_valid;
    pixel_pair_t [N-1:0] exp_pair;
    int                  value_errs [N];
    int                  pulse_errs [N];
    int                  pending [N];

    step_t       steps [MAX_STEPS];
    int          num_steps = 0;
    col_t        tbl_cols;
    logic [31:0] rng;
    int          cycle_count = 0;

    // Reference banks with index 0 for the even RAM and 1 for the odd RAM
    pixel_t ref_mem [N][2][`AWE_RAM_DEPTH];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    awe_row_buffers i_awe_row_buffers (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .load           (load),
        .pix_in         (pix_in),
        .num_input_cols (num_input_cols),
        .gray_code      (gray_code),
        .seq_word       (seq_word),
        .ce_start       (ce_start),
        .row_matric     (row_matric),
        .last_kernel    (last_kernel),
        .wr_col         (wr_col),
        .pair_out       (pair_out),
        .pair_valid     (pair_valid)
    );

    for (genvar g = 0; g < N; g++) begin : g_check
        awe_checker #(
            .ENGINE (g)
        ) u_checker (
            .clk          (clk),
            .rst          (rst),
            .exp_valid    (exp_valid[g]),
            .exp_pair     (exp_pair[g]),
            .pair_valid   (pair_valid[g]),
            .pair_out     (pair_out[g]),
            .value_errors (value_errs[g]),
            .pulse_errors (pulse_errs[g]),
            .pending      (pending[g])
        );
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > num_steps * 6 + 50) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Table construction
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic step_t blank(input awe_state_t st);
        step_t s;
        s           = '0;
        s.state     = st;
        s.num_cols  = tbl_cols;
        s.seq.spare = 5'h15;
        return s;
    endfunction

    // Adds a step and keeps the reference banks in step with it
    task automatic push_step(input step_t s);
        step_t     t;
        step_t     old;
        ram_addr_t ea;
        ram_addr_t oa;
        int        ram;
        t = s;
        for (int e = 0; e < N; e++) begin
            rng      = xorshift32(rng);
            t.pix[e] = rng[15:0];
        end
        ea = {t.gray[0] ^ t.seq.flip, t.seq.col};
        oa = {t.gray[1] ^ t.seq.flip, t.seq.col | col_t'(t.seq.parity)};
        for (int e = 0; e < N; e++) begin
            t.exp[e] = '0;
            if (t.state == ST_ACTIVE && t.start[e]) begin
                t.exp[e] = {ref_mem[e][1][oa], ref_mem[e][0][ea]};
                // New row uses the pixel aligned two steps back
                if (t.row_matric && t.last_kernel && num_steps >= 2) begin
                    ram = (t.gray[0] == t.gray[1]) ? 1 : 0;
                    ref_mem[e][ram][{t.gray[0], t.wr_col}] = steps[num_steps-2].pix[e];
                end
            end
        end
        // Delayed load meets the state of this step
        if (num_steps >= 2) begin
            old = steps[num_steps-2];
            if (t.state == ST_PRIME_BUFFER && old.load.strobe &&
                old.load.col <= t.num_cols) begin
                for (int e = 0; e < N; e++) begin
                    if (old.load.row == 0 || old.load.row == 2) begin
                        ref_mem[e][0][{old.load.row != 0, old.load.col}] = old.pix[e];
                    end
                    if (old.load.row == 0 || old.load.row == 1) begin
                        ref_mem[e][1][{old.load.row != 0, old.load.col}] = old.pix[e];
                    end
                end
            end
        end
        steps[num_steps] = t;
        num_steps        = num_steps + 1;
    endtask

    task automatic idle_steps(input awe_state_t st, input int count);
        for (int i = 0; i < count; i++) begin
            push_step(blank(st));
        end
    endtask

    task automatic load_step(input awe_state_t st, input int row, input int col);
        step_t s;
        s             = blank(st);
        s.load.strobe = 1'b1;
        s.load.row    = col_t'(row);
        s.load.col    = col_t'(col);
        push_step(s);
    endtask

    task automatic read_step(input logic [N-1:0] start, input gray_t gray,
                             input logic flip, input int col, input logic parity);
        step_t s;
        s            = blank(ST_ACTIVE);
        s.start      = start;
        s.gray       = gray;
        s.seq.flip   = flip;
        s.seq.col    = col_t'(col);
        s.seq.parity = parity;
        push_step(s);
    endtask

    task automatic update_step(input logic [N-1:0] start, input gray_t gray,
                               input int col, input logic rm, input logic lk);
        step_t s;
        s             = blank(ST_ACTIVE);
        s.start       = start;
        s.gray        = gray;
        s.wr_col      = col_t'(col);
        s.seq.col     = col_t'(col);
        s.row_matric  = rm;
        s.last_kernel = lk;
        push_step(s);
    endtask

    task automatic build_table();
        step_t s;
        tbl_cols = 9'd31;
        idle_steps(ST_IDLE, 4);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 32; c++) begin
                load_step(ST_PRIME_BUFFER, r, c);
            end
        end
        idle_steps(ST_PRIME_BUFFER, 2);
        // Loads past the last column and rows above 2
        tbl_cols = 9'd20;
        for (int k = 0; k < 6; k++) begin
            load_step(ST_PRIME_BUFFER, k, (k < 3) ? 21 + k : k);
        end
        idle_steps(ST_PRIME_BUFFER, 2);
        load_step(ST_WAIT_LOAD, 0, 3);
        idle_steps(ST_WAIT_LOAD, 4);
        // Even columns so that parity moves the odd RAM column
        for (int g = 0; g < 4; g++) begin
            for (int f = 0; f < 2; f++) begin
                for (int p = 0; p < 2; p++) begin
                    rng = xorshift32(rng);
                    read_step(2'b11, gray_t'(g), f[0], int'({rng[4:1], 1'b0}), p[0]);
                end
            end
        end
        for (int k = 0; k < 6; k++) begin
            read_step(2'b11, 2'b00, 1'b0, (k < 3) ? 3 + k : 18 + k, 1'b0);
            read_step(2'b11, 2'b11, 1'b0, (k < 3) ? 3 + k : 18 + k, 1'b0);
        end
        idle_steps(ST_ACTIVE, 2);
        update_step(2'b11, 2'b00, 4, 1'b1, 1'b1);
        update_step(2'b11, 2'b11, 5, 1'b1, 1'b1);
        update_step(2'b11, 2'b01, 6, 1'b1, 1'b1);
        update_step(2'b11, 2'b10, 7, 1'b1, 1'b1);
        update_step(2'b11, 2'b00, 8, 1'b1, 1'b0);
        update_step(2'b11, 2'b01, 9, 1'b0, 1'b1);
        update_step(2'b01, 2'b11, 10, 1'b1, 1'b1);
        idle_steps(ST_ACTIVE, 3);
        for (int c = 4; c <= 10; c++) begin
            read_step(2'b11, 2'b00, 1'b0, c, 1'b0);
            read_step(2'b11, 2'b11, 1'b0, c, 1'b0);
        end
        read_step(2'b01, 2'b10, 1'b0, 10, 1'b1);
        read_step(2'b10, 2'b01, 1'b1, 6, 1'b0);
        // No read outside the active state
        s       = blank(ST_WAIT_LOAD);
        s.start = 2'b11;
        push_step(s);
        idle_steps(ST_IDLE, 6);
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic drive_step(input step_t s);
        state          = s.state;
        load           = s.load;
        pix_in         = s.pix;
        num_input_cols = s.num_cols;
        gray_code      = s.gray;
        seq_word       = s.seq;
        ce_start       = s.start;
        row_matric     = s.row_matric;
        last_kernel    = s.last_kernel;
        wr_col         = s.wr_col;
        exp_pair       = s.exp;
        for (int e = 0; e < N; e++) begin
            exp_valid[e] = (s.state == ST_ACTIVE) && s.start[e];
        end
    endtask

    initial begin
        int value_total;
        int pulse_total;
        rng = 32'h8f976ad1;
        build_table();
        rst = 1'b1;
        drive_step(blank(ST_IDLE));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_steps; i++) begin
            drive_step(steps[i]);
            @(negedge clk);
        end
        drive_step(blank(ST_IDLE));
        @(posedge clk);
        while (pending.sum() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
        value_total = value_errs.sum();
        pulse_total = pulse_errs.sum();
        $display("Error count: %0d value mismatches, %0d missing or unexpected pulses",
                 value_total, pulse_total);
        if (value_total + pulse_total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim/awe_checker.sv */
`timescale 1ns/1ps

module awe_checker #(
    parameter int ENGINE = 0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       exp_valid,
    input  awe_types_pkg::pixel_pair_t exp_pair,
    input  logic                       pair_valid,
    input  awe_types_pkg::pixel_pair_t pair_out,
    output int                         value_errors,
    output int                         pulse_errors,
    output int                         pending
);

    import awe_types_pkg::*;

    pixel_pair_t exp_q [$];
    int          due_q [$];
    int          cyc = 0;

    initial begin
        value_errors = 0;
        pulse_errors = 0;
        pending      = 0;
    end

    // Expected pair is taken on the edge that samples ce_start
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst && exp_valid) begin
            exp_q.push_back(exp_pair);
            due_q.push_back(cyc + 2);
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            if (pair_valid !== 1'b1) begin
                $display("Engine %0d: pair_valid missing at time %0t, two cycles after a read",
                         ENGINE, $time);
                pulse_errors = pulse_errors + 1;
            end else if (pair_out !== exp_q[0]) begin
                $display("Error: time %0t, pair_out[%0d] expected %h, actual %h",
                         $time, ENGINE, exp_q[0], pair_out);
                value_errors = value_errors + 1;
            end
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end else if (pair_valid !== 1'b0) begin
            $display("Engine %0d: pair_valid raised at time %0t with no read in flight",
                     ENGINE, $time);
            pulse_errors = pulse_errors + 1;
        end
        pending = due_q.size();
    end

endmodule

/* source/awe_row_buffers.sv */
`timescale 1ns/1ps
`include "awe_defines.svh"

module awe_row_buffers (
    input  logic                          clk,
    input  logic                          rst,
    input  awe_ctrl_pkg::awe_state_t      state,
    input  awe_types_pkg::load_req_t      load,
    input  awe_types_pkg::engine_pixels_t pix_in,
    input  awe_types_pkg::col_t           num_input_cols,
    input  awe_ctrl_pkg::gray_t           gray_code,
    input  awe_ctrl_pkg::seq_word_t       seq_word,
    input  logic [`AWE_NUM_ENGINES-1:0]   ce_start,
    input  logic                          row_matric,
    input  logic                          last_kernel,
    input  awe_types_pkg::col_t           wr_col,
    output awe_types_pkg::pixel_pair_t [`AWE_NUM_ENGINES-1:0] pair_out,
    output logic [`AWE_NUM_ENGINES-1:0]   pair_valid
);

    import awe_types_pkg::*;

    engine_pixels_t pix_aligned;
    prime_wr_t [`AWE_NUM_ENGINES-1:0] prime_wr;

    //////////////////////////////
    // Input side
    //////////////////////////////

    load_aligner u_load_aligner (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .load           (load),
        .pix_in         (pix_in),
        .num_input_cols (num_input_cols),
        .pix_aligned    (pix_aligned),
        .prime_wr       (prime_wr)
    );

    //////////////////////////////
    // Engine banks
    //////////////////////////////

    // Each engine sees the shared sequencer and gray code
    for (genvar g = 0; g < `AWE_NUM_ENGINES; g++) begin : g_engine
        engine_bank u_engine_bank (
            .clk         (clk),
            .rst         (rst),
            .state       (state),
            .prime_wr    (prime_wr[g]),
            .pix         (pix_aligned[g]),
            .gray_code   (gray_code),
            .seq_word    (seq_word),
            .ce_start    (ce_start[g]),
            .row_matric  (row_matric),
            .last_kernel (last_kernel),
            .wr_col      (wr_col),
            .pair_out    (pair_out[g]),
            .pair_valid  (pair_valid[g])
        );
    end

endmodule

/* source/engine_bank.sv */
`timescale 1ns/1ps
`include "awe_defines.svh"

module engine_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  awe_ctrl_pkg::awe_state_t  state,
    input  awe_types_pkg::prime_wr_t  prime_wr,
    input  awe_types_pkg::pixel_t     pix,
    input  awe_ctrl_pkg::gray_t       gray_code,
    input  awe_ctrl_pkg::seq_word_t   seq_word,
    input  logic                      ce_start,
    input  logic                      row_matric,
    input  logic                      last_kernel,
    input  awe_types_pkg::col_t       wr_col,
    output awe_types_pkg::pixel_pair_t pair_out,
    output logic                      pair_valid
);

    import awe_types_pkg::*;
    import awe_ctrl_pkg::*;

    logic      active_start;
    logic      upd_hit;

    // Incoming-row write, registered one cycle
    logic      upd_en_even;
    logic      upd_en_odd;
    ram_addr_t upd_addr;
    pixel_t    upd_data;

    ram_wr_t   even_wr;
    ram_wr_t   odd_wr;

    // Read side
    ram_addr_t even_rd_nxt;
    ram_addr_t odd_rd_nxt;
    ram_addr_t even_rd_addr;
    ram_addr_t odd_rd_addr;
    logic      rd_en;
    logic      rd_vld;
    pixel_t    even_rd_data;
    pixel_t    odd_rd_data;

    assign active_start = (state == ST_ACTIVE) && ce_start;
    assign upd_hit      = active_start && row_matric && last_kernel;

    //////////////////////////////
    // Write path
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            upd_en_even <= 1'b0;
            upd_en_odd  <= 1'b0;
        end else begin
            // Equal gray bits send the new row to the odd RAM
            upd_en_odd  <= upd_hit && (gray_code[0] == gray_code[1]);
            upd_en_even <= upd_hit && (gray_code[0] != gray_code[1]);
        end
    end

    always_ff @(posedge clk) begin
        upd_addr <= {gray_code[0], wr_col};
        upd_data <= pix;
    end

    // Priming and update never overlap in state, priming wins anyway
    always_comb begin
        even_wr = prime_wr.even;
        if (!prime_wr.even.en) begin
            even_wr.en   = upd_en_even;
            even_wr.addr = upd_addr;
            even_wr.data = upd_data;
        end
        odd_wr = prime_wr.odd;
        if (!prime_wr.odd.en) begin
            odd_wr.en   = upd_en_odd;
            odd_wr.addr = upd_addr;
            odd_wr.data = upd_data;
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    // Window address decode
    assign even_rd_nxt = {gray_code[0] ^ seq_word.flip, seq_word.col};
    assign odd_rd_nxt  = {gray_code[1] ^ seq_word.flip,
                          seq_word.col[`AWE_COL_WIDTH-1:1],
                          seq_word.col[0] | seq_word.parity};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en  <= 1'b0;
            rd_vld <= 1'b0;
        end else begin
            rd_en  <= active_start;
            rd_vld <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        even_rd_addr <= even_rd_nxt;
        odd_rd_addr  <= odd_rd_nxt;
    end

    row_buf_ram #(
        .DEPTH (`AWE_RAM_DEPTH)
    ) u_even_ram (
        .clk     (clk),
        .wr      (even_wr),
        .rd_en   (rd_en),
        .rd_addr (even_rd_addr),
        .rd_data (even_rd_data)
    );

    row_buf_ram #(
        .DEPTH (`AWE_RAM_DEPTH)
    ) u_odd_ram (
        .clk     (clk),
        .wr      (odd_wr),
        .rd_en   (rd_en),
        .rd_addr (odd_rd_addr),
        .rd_data (odd_rd_data)
    );

    // Output pair, one pulse per read
    always_ff @(posedge clk) begin
        if (rst) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= rd_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_vld) begin
            pair_out.odd  <= odd_rd_data;
            pair_out.even <= even_rd_data;
        end
    end

endmodule

/* source/load_aligner.sv */
`timescale 1ns/1ps
`include "awe_defines.svh"

module load_aligner (
    input  logic                          clk,
    input  logic                          rst,
    input  awe_ctrl_pkg::awe_state_t      state,
    input  awe_types_pkg::load_req_t      load,
    input  awe_types_pkg::engine_pixels_t pix_in,
    input  awe_types_pkg::col_t           num_input_cols,
    output awe_types_pkg::engine_pixels_t pix_aligned,
    output awe_types_pkg::prime_wr_t [`AWE_NUM_ENGINES-1:0] prime_wr
);

    import awe_types_pkg::*;
    import awe_ctrl_pkg::*;

    load_req_t load_d;
    logic      prime_hit;
    prime_wr_t [`AWE_NUM_ENGINES-1:0] prime_nxt;

    //////////////////////////////
    // Upstream alignment
    //////////////////////////////

    delay_line #(
        .payload_t (load_req_t),
        .STAGES    (`AWE_LOAD_DELAY)
    ) u_load_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (load),
        .dout (load_d)
    );

    delay_line #(
        .payload_t (engine_pixels_t),
        .STAGES    (`AWE_LOAD_DELAY)
    ) u_pix_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (pix_in),
        .dout (pix_aligned)
    );

    //////////////////////////////
    // Priming decode
    //////////////////////////////

    // Columns past the last input column are dropped
    assign prime_hit = (state == ST_PRIME_BUFFER) && load_d.strobe &&
                       (load_d.col <= num_input_cols);

    always_comb begin
        prime_nxt = '0;
        for (int e = 0; e < `AWE_NUM_ENGINES; e++) begin
            prime_nxt[e].even.data = pix_aligned[e];
            prime_nxt[e].odd.data  = pix_aligned[e];
            case (load_d.row)
                col_t'(0): begin
                    // Row 0 fills the lower bank of both RAMs
                    prime_nxt[e].even.en   = prime_hit;
                    prime_nxt[e].even.addr = {1'b0, load_d.col};
                    prime_nxt[e].odd.en    = prime_hit;
                    prime_nxt[e].odd.addr  = {1'b0, load_d.col};
                end
                col_t'(1): begin
                    prime_nxt[e].odd.en   = prime_hit;
                    prime_nxt[e].odd.addr = {1'b1, load_d.col};
                end
                col_t'(2): begin
                    prime_nxt[e].even.en   = prime_hit;
                    prime_nxt[e].even.addr = {1'b1, load_d.col};
                end
                default: begin
                    prime_nxt[e] = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prime_wr <= '0;
        end else begin
            prime_wr <= prime_nxt;
        end
    end

endmodule

/* source/row_buf_ram.sv */
`timescale 1ns/1ps
`include "awe_defines.svh"

module row_buf_ram #(
    parameter int DEPTH = `AWE_RAM_DEPTH
) (
    input  logic                    clk,
    input  awe_types_pkg::ram_wr_t  wr,
    input  logic                    rd_en,
    input  awe_types_pkg::ram_addr_t rd_addr,
    output awe_types_pkg::pixel_t   rd_data
);

    import awe_types_pkg::*;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read before write on a shared address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* source/delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  STAGES    = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [STAGES];

    // Plain shift chain, every stage cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[STAGES-1];

endmodule

/* source/awe_ctrl_pkg.sv */
`include "awe_defines.svh"

package awe_ctrl_pkg;

    // Accelerator state, one-hot
    typedef enum logic [4:0] {
        ST_IDLE         = 5'b00001,
        ST_PRIME_BUFFER = 5'b00010,
        ST_WAIT_LOAD    = 5'b00100,
        ST_ACTIVE       = 5'b01000,
        ST_DONE         = 5'b10000
    } awe_state_t;

    // Row rotation, bit 0 for the even RAM and bit 1 for the odd RAM
    typedef logic [1:0] gray_t;

    //////////////////////////////
    // Sequencer word
    //////////////////////////////

    // flip inverts both bank bits, parity forces odd column LSB
    typedef struct packed {
        logic                     flip;
        logic [`AWE_COL_WIDTH-1:0] col;
        logic                     parity;
        logic [4:0]               spare;
    } seq_word_t;

endpackage

/* source/awe_types_pkg.sv */
`include "awe_defines.svh"

package awe_types_pkg;

    // Basic data path words
    typedef logic [`AWE_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`AWE_COL_WIDTH-1:0]   col_t;

    // Top bit picks the bank, the rest is the column
    typedef logic [`AWE_ADDR_WIDTH-1:0]  ram_addr_t;

    // Window read result, odd RAM in the upper half
    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } pixel_pair_t;

    // One pixel per convolution engine
    typedef pixel_t [`AWE_NUM_ENGINES-1:0] engine_pixels_t;

    // Single RAM write port command
    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        pixel_t    data;
    } ram_wr_t;

    // Upstream load request
    typedef struct packed {
        logic strobe;
        col_t row;
        col_t col;
    } load_req_t;

    // Priming writes for both RAMs of one engine
    typedef struct packed {
        ram_wr_t even;
        ram_wr_t odd;
    } prime_wr_t;

endpackage

/* source/awe_defines.svh */
`ifndef AWE_DEFINES_SVH
`define AWE_DEFINES_SVH

//////////////////////////////
// Data path widths
//////////////////////////////

// Bits per pixel
`define AWE_PIXEL_WIDTH 16

// Words per row RAM, two banks of one row each
`define AWE_RAM_DEPTH 1024
`define AWE_ADDR_WIDTH 10

// Column and row index, one bank wide
`define AWE_COL_WIDTH 9

//////////////////////////////
// Pipeline and structure
//////////////////////////////

// Cycles to line up with the upstream row buffer
`define AWE_LOAD_DELAY 2
`define AWE_NUM_ENGINES 2

`endif
